/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memcopy testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_memcopy -f verilog.f \
  -o sim_memcopy > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_memcopy > sim.log 2>&1 \
  || { echo "Simulation did not run to the end, see sim.log"; exit 1; }

grep -q "^TESTS PASSED$" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }

/* test/tb_memcopy.sv */
// ---------------------------------------------------------
// Directed testbench for the memory-copy peripheral with a
// memory model, register tasks and copy checks
// ---------------------------------------------------------
`timescale 1ns/1ns

module tb_memcopy;

  import memcopy_pkg::*;

  localparam int unsigned MEM_WORDS    = 256;
  localparam int          DONE_TIMEOUT = 200;
  // Offset outside the register map
  localparam reg_addr_t   BAD_OFFSET   = 4'hE;

  logic        clk_i;
  logic        rst_ni;
  logic        reg_valid;
  logic        reg_we;
  reg_addr_t   reg_addr;
  data_t       reg_wdata;
  data_t       reg_rdata;
  logic        reg_ready;
  logic        reg_error;
  logic        host_req;
  logic        host_we;
  addr_t       host_addr;
  data_t       host_wdata;
  data_t       host_rdata;
  logic        mem_stall;

  logic        stall_en;
  logic [31:0] rng_state;
  logic [31:0] stall_state;
  data_t       model [MEM_WORDS];
  int          errors;
  int          checks;

  memcopy_top #(
    .MEM_WORDS (MEM_WORDS)
  ) i_memcopy_top (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .reg_valid_i      (reg_valid),
    .reg_write_i      (reg_we),
    .reg_addr_i       (reg_addr),
    .reg_wdata_i      (reg_wdata),
    .reg_rdata_o      (reg_rdata),
    .reg_ready_o      (reg_ready),
    .reg_error_o      (reg_error),
    .host_mem_req_i   (host_req),
    .host_mem_we_i    (host_we),
    .host_mem_addr_i  (host_addr),
    .host_mem_wdata_i (host_wdata),
    .host_mem_rdata_o (host_rdata),
    .mem_stall_i      (mem_stall)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Random stall with one new value per cycle while enabled
  always @(posedge clk_i) begin
    if (stall_en) begin
      stall_state = lcg(stall_state);
      mem_stall <= stall_state[16];
    end else begin
      mem_stall <= 1'b0;
    end
  end

  function automatic int word_index(input addr_t a);
    return int'((a >> 2) & addr_t'(MEM_WORDS - 1));
  endfunction

  task automatic check_word(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic reg_write(input reg_addr_t addr, input data_t data, output logic err);
    @(posedge clk_i);
    reg_valid <= 1'b1;
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(negedge clk_i);
    err = reg_error;
    check_word("ready during write", 32'(reg_ready), 32'd1);
    @(posedge clk_i);
    reg_valid <= 1'b0;
    reg_we    <= 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output data_t data, output logic err);
    @(posedge clk_i);
    reg_valid <= 1'b1;
    reg_we    <= 1'b0;
    reg_addr  <= addr;
    @(negedge clk_i);
    data = reg_rdata;
    err  = reg_error;
    check_word("ready during read", 32'(reg_ready), 32'd1);
    @(posedge clk_i);
    reg_valid <= 1'b0;
  endtask

  task automatic mem_write(input addr_t addr, input data_t data);
    @(posedge clk_i);
    host_req   <= 1'b1;
    host_we    <= 1'b1;
    host_addr  <= addr;
    host_wdata <= data;
    @(posedge clk_i);
    host_req   <= 1'b0;
    host_we    <= 1'b0;
  endtask

  task automatic mem_read(input addr_t addr, output data_t data);
    @(posedge clk_i);
    host_req  <= 1'b1;
    host_we   <= 1'b0;
    host_addr <= addr;
    @(posedge clk_i);
    host_req  <= 1'b0;
    @(negedge clk_i);
    data = host_rdata;
  endtask

  // Polls DONE until it reads 1 or the poll budget runs out
  task automatic wait_done();
    data_t status;
    logic  err;
    int    polls;
    status = '0;
    polls  = 0;
    while (status[0] !== 1'b1 && polls < DONE_TIMEOUT) begin
      reg_read(REG_DONE, status, err);
      polls++;
    end
    if (status[0] !== 1'b1) begin
      errors++;
      $display("Timeout: the copy did not finish within %0d status polls", DONE_TIMEOUT);
    end
  endtask

  task automatic fill_source(input addr_t src, input int count);
    for (int i = 0; i < count; i++) begin
      rng_state = lcg(rng_state);
      mem_write(src + addr_t'(i * 4), rng_state);
      model[word_index(src + addr_t'(i * 4))] = rng_state;
    end
  endtask

  // Model of a copy in increasing address order
  task automatic model_copy(input addr_t src, input addr_t dst, input int count);
    for (int i = 0; i < count; i++) begin
      model[word_index(dst + addr_t'(i * 4))] = model[word_index(src + addr_t'(i * 4))];
    end
  endtask

  task automatic check_memory();
    data_t d;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_read(addr_t'(i * 4), d);
      check_word($sformatf("memory word %0d", i), d, model[i]);
    end
  endtask

  task automatic start_copy(input addr_t src, input addr_t dst, input int count);
    logic err;
    reg_write(REG_PTR_READ, src, err);
    reg_write(REG_PTR_WRITE, dst, err);
    reg_write(REG_CNT_START, count_t'(count), err);
    check_word("error flag on start", 32'(err), 32'd0);
  endtask

  initial begin
    data_t d;
    data_t saved [3];
    logic  err;

    rst_ni      = 1'b0;
    reg_valid   = 1'b0;
    reg_we      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    host_req    = 1'b0;
    host_we     = 1'b0;
    host_addr   = '0;
    host_wdata  = '0;
    mem_stall   = 1'b0;
    stall_en    = 1'b0;
    rng_state   = 32'h1add;
    stall_state = 32'h1add;
    errors      = 0;
    checks      = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Reset values
    reg_read(REG_DONE, d, err);
    check_word("DONE after reset", d, 32'd1);
    check_word("error flag after reset", 32'(err), 32'd0);
    reg_read(REG_PTR_READ, d, err);
    check_word("PTR_READ after reset", d, 32'd0);
    reg_read(REG_PTR_WRITE, d, err);
    check_word("PTR_WRITE after reset", d, 32'd0);
    reg_read(REG_CNT_START, d, err);
    check_word("CNT_START after reset", d, 32'd0);

    // Known contents everywhere derived from the full byte address
    for (int i = 0; i < MEM_WORDS; i++) begin
      model[i] = 32'h5a00_0000 ^ addr_t'(i * 4);
      mem_write(addr_t'(i * 4), model[i]);
    end

    // Plain 16-word copy
    fill_source(32'h000, 16);
    start_copy(32'h000, 32'h100, 16);
    model_copy(32'h000, 32'h100, 16);
    wait_done();
    check_memory();

    // Zero count starts nothing
    reg_write(REG_CNT_START, 32'd0, err);
    reg_read(REG_DONE, d, err);
    check_word("DONE after zero count", d, 32'd1);
    reg_read(REG_CNT_START, d, err);
    check_word("count after zero write", d, 32'd0);
    check_memory();

    // Copy under random stall
    fill_source(32'h200, 16);
    stall_en <= 1'b1;
    start_copy(32'h200, 32'h300, 16);
    model_copy(32'h200, 32'h300, 16);
    wait_done();
    stall_en <= 1'b0;
    check_memory();

    // A second start while busy must be ignored
    fill_source(32'h080, 32);
    start_copy(32'h080, 32'h180, 32);
    model_copy(32'h080, 32'h180, 32);
    reg_write(REG_PTR_READ, 32'h000, err);
    reg_write(REG_PTR_WRITE, 32'h200, err);
    reg_read(REG_DONE, d, err);
    check_word("DONE while busy", d, 32'd0);
    reg_write(REG_CNT_START, 32'd8, err);
    wait_done();
    reg_read(REG_CNT_START, d, err);
    check_word("count after ignored start", d, 32'd32);
    check_memory();

    // Unmapped offset
    reg_read(REG_PTR_READ, saved[0], err);
    reg_read(REG_PTR_WRITE, saved[1], err);
    reg_read(REG_CNT_START, saved[2], err);
    reg_write(BAD_OFFSET, 32'hdead_beef, err);
    check_word("error flag on bad write", 32'(err), 32'd1);
    reg_read(BAD_OFFSET, d, err);
    check_word("error flag on bad read", 32'(err), 32'd1);
    check_word("bad read data", d, 32'd0);
    reg_read(REG_PTR_READ, d, err);
    check_word("PTR_READ after bad write", d, saved[0]);
    reg_read(REG_PTR_WRITE, d, err);
    check_word("PTR_WRITE after bad write", d, saved[1]);
    reg_read(REG_CNT_START, d, err);
    check_word("CNT_START after bad write", d, saved[2]);
    reg_read(REG_DONE, d, err);
    check_word("DONE after bad write", d, 32'd1);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/memcopy_pkg.sv
verilog/memcopy_regs.sv
verilog/memcopy_engine.sv
verilog/memcopy_sram.sv
verilog/memcopy_top.sv
test/tb_memcopy.sv

/* verilog/memcopy_engine.sv */
// ---------------------------------------------------------
// Copy engine that reads one word, buffers it and writes it
// to the destination for each word of the count
// ---------------------------------------------------------
`timescale 1ns/1ns

module memcopy_engine (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Control from the register file
  input  logic                start_i,
  input  memcopy_pkg::addr_t  ptr_read_i,
  input  memcopy_pkg::addr_t  ptr_write_i,
  input  memcopy_pkg::count_t count_i,
  output logic                done_o,

  // Memory request port
  output logic                mem_req_o,
  output logic                mem_we_o,
  output memcopy_pkg::addr_t  mem_addr_o,
  output memcopy_pkg::data_t  mem_wdata_o,
  input  logic                mem_gnt_i,
  input  logic                mem_rvalid_i,
  input  memcopy_pkg::data_t  mem_rdata_i
);

  import memcopy_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE,
    ST_FINISH
  } state_e;

  state_e state_q;
  state_e state_d;

  // Working copies of the programmed transfer
  addr_t  rd_ptr_q;
  addr_t  wr_ptr_q;
  count_t remain_q;

  // Read granted but data not yet returned
  logic   rd_pending_q;
  data_t  wdata_q;

  logic   rd_grant;
  logic   wr_grant;
  logic   rdata_in;

  assign rd_grant = mem_req_o & ~mem_we_o & mem_gnt_i;
  assign rdata_in = rd_pending_q & mem_rvalid_i;

  always_comb begin
    state_d    = state_q;
    done_o     = 1'b0;
    wr_grant   = 1'b0;
    mem_req_o  = 1'b0;
    mem_we_o   = 1'b0;
    mem_addr_o = '0;

    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_READ;
        end
      end

      ST_READ: begin
        if (remain_q == '0) begin
          state_d = ST_FINISH;
        end else begin
          mem_req_o  = 1'b1;
          mem_addr_o = rd_ptr_q;
          if (mem_gnt_i) begin
            state_d = ST_WRITE;
          end
        end
      end

      ST_WRITE: begin
        // The SRAM holds off the grant until the read data is back,
        // so the write request can go out right away
        mem_req_o  = 1'b1;
        mem_we_o   = 1'b1;
        mem_addr_o = wr_ptr_q;
        if (mem_gnt_i) begin
          wr_grant = 1'b1;
          state_d  = ST_READ;
        end
      end

      ST_FINISH: begin
        done_o  = 1'b1;
        state_d = ST_IDLE;
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Latch the job on start and advance after every granted write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      remain_q <= '0;
    end else if (start_i && state_q == ST_IDLE) begin
      rd_ptr_q <= ptr_read_i;
      wr_ptr_q <= ptr_write_i;
      remain_q <= count_i;
    end else if (wr_grant) begin
      rd_ptr_q <= rd_ptr_q + 32'd4;
      wr_ptr_q <= wr_ptr_q + 32'd4;
      remain_q <= remain_q - 32'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pending_q <= 1'b0;
    end else if (rd_grant) begin
      rd_pending_q <= 1'b1;
    end else if (mem_rvalid_i) begin
      rd_pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_in) begin
      wdata_q <= mem_rdata_i;
    end
  end

  // Forward the returning word so write data is stable for the whole request
  assign mem_wdata_o = rdata_in ? mem_rdata_i : wdata_q;

endmodule

/* verilog/memcopy_pkg.sv */
// ---------------------------------------------------------
// Shared types and register offsets of the memory-copy
// peripheral
// ---------------------------------------------------------
package memcopy_pkg;

  // Data word moved by the engine and stored in the SRAM
  typedef logic [31:0] data_t;

  // Byte address for the pointers and the memory port
  typedef logic [31:0] addr_t;

  // Byte offset on the register bus
  typedef logic [3:0] reg_addr_t;

  // Number of words to copy
  typedef logic [31:0] count_t;

  // Register map
  // PTR_READ  source byte address
  // PTR_WRITE destination byte address
  // CNT_START word count that starts the copy when nonzero
  // DONE      bit 0 is high while the engine is idle
  localparam reg_addr_t REG_PTR_READ  = 4'h0;
  localparam reg_addr_t REG_PTR_WRITE = 4'h4;
  localparam reg_addr_t REG_CNT_START = 4'h8;
  localparam reg_addr_t REG_DONE      = 4'hC;

endpackage

/* verilog/memcopy_regs.sv */
// ---------------------------------------------------------
// Register file with host bus decoding, start pulse and
// done status
// ---------------------------------------------------------
`timescale 1ns/1ns

module memcopy_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Host register bus
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  memcopy_pkg::reg_addr_t reg_addr_i,
  input  memcopy_pkg::data_t    reg_wdata_i,
  output memcopy_pkg::data_t    reg_rdata_o,
  output logic                  reg_ready_o,
  output logic                  reg_error_o,

  // Copy engine control
  output logic                  start_o,
  output memcopy_pkg::addr_t    ptr_read_o,
  output memcopy_pkg::addr_t    ptr_write_o,
  output memcopy_pkg::count_t   count_o,
  input  logic                  done_i
);

  import memcopy_pkg::*;

  addr_t  ptr_read_q;
  addr_t  ptr_write_q;
  count_t count_q;
  logic   done_q;
  logic   start_q;

  logic   addr_hit;
  logic   wr_en;
  data_t  rdata;

  // Address decode and read mux
  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (reg_addr_i)
      REG_PTR_READ:  rdata = ptr_read_q;
      REG_PTR_WRITE: rdata = ptr_write_q;
      REG_CNT_START: rdata = count_q;
      REG_DONE:      rdata = {31'b0, done_q};
      default: begin
        addr_hit = 1'b0;
      end
    endcase
  end

  assign wr_en       = reg_valid_i & reg_write_i & addr_hit;
  assign reg_ready_o = reg_valid_i;
  assign reg_error_o = reg_valid_i & ~addr_hit;
  assign reg_rdata_o = rdata;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_read_q  <= '0;
      ptr_write_q <= '0;
      count_q     <= '0;
      done_q      <= 1'b1;
      start_q     <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (done_i) begin
        done_q <= 1'b1;
      end
      if (wr_en) begin
        case (reg_addr_i)
          REG_PTR_READ:  ptr_read_q  <= reg_wdata_i;
          REG_PTR_WRITE: ptr_write_q <= reg_wdata_i;
          REG_CNT_START: begin
            // Only accepted while no copy is running
            if (done_q) begin
              count_q <= reg_wdata_i;
              if (|reg_wdata_i) begin
                done_q  <= 1'b0;
                start_q <= 1'b1;
              end
            end
          end
          default: begin
            // DONE is read only
          end
        endcase
      end
    end
  end

  assign start_o     = start_q;
  assign ptr_read_o  = ptr_read_q;
  assign ptr_write_o = ptr_write_q;
  assign count_o     = count_q;

endmodule

/* verilog/memcopy_sram.sv */
// ---------------------------------------------------------
// Dual-port word SRAM with a granted request port for the
// engine and a direct port for the host
// ---------------------------------------------------------
`timescale 1ns/1ns

module memcopy_sram #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Engine port
  input  logic               mem_req_i,
  input  logic               mem_we_i,
  input  memcopy_pkg::addr_t mem_addr_i,
  input  memcopy_pkg::data_t mem_wdata_i,
  output logic               mem_gnt_o,
  output logic               mem_rvalid_o,
  output memcopy_pkg::data_t mem_rdata_o,
  input  logic               mem_stall_i,

  // Host port
  input  logic               host_req_i,
  input  logic               host_we_i,
  input  memcopy_pkg::addr_t host_addr_i,
  input  memcopy_pkg::data_t host_wdata_i,
  output memcopy_pkg::data_t host_rdata_o
);

  import memcopy_pkg::*;

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  data_t            mem_q [MEM_WORDS];
  data_t            mem_rdata_q;
  data_t            host_rdata_q;
  logic             rvalid_q;

  logic [IDX_W-1:0] mem_idx;
  logic [IDX_W-1:0] host_idx;

  // Word index that wraps at the depth
  assign mem_idx  = mem_addr_i[IDX_W+1:2];
  assign host_idx = host_addr_i[IDX_W+1:2];

  // No grant while a read response is on the bus
  assign mem_gnt_o = mem_req_i & ~mem_stall_i & ~rvalid_q;

  always_ff @(posedge clk_i) begin
    if (mem_gnt_o) begin
      if (mem_we_i) begin
        mem_q[mem_idx] <= mem_wdata_i;
      end else begin
        mem_rdata_q <= mem_q[mem_idx];
      end
    end
    if (host_req_i) begin
      if (host_we_i) begin
        mem_q[host_idx] <= host_wdata_i;
      end else begin
        host_rdata_q <= mem_q[host_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= mem_gnt_o & ~mem_we_i;
    end
  end

  assign mem_rvalid_o = rvalid_q;
  assign mem_rdata_o  = mem_rdata_q;
  assign host_rdata_o = host_rdata_q;

endmodule

/* verilog/memcopy_top.sv */
// ---------------------------------------------------------
// Memory-copy peripheral top level
// ---------------------------------------------------------
`timescale 1ns/1ns

module memcopy_top #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  memcopy_pkg::reg_addr_t reg_addr_i,
  input  memcopy_pkg::data_t     reg_wdata_i,
  output memcopy_pkg::data_t     reg_rdata_o,
  output logic                   reg_ready_o,
  output logic                   reg_error_o,

  input  logic                   host_mem_req_i,
  input  logic                   host_mem_we_i,
  input  memcopy_pkg::addr_t     host_mem_addr_i,
  input  memcopy_pkg::data_t     host_mem_wdata_i,
  output memcopy_pkg::data_t     host_mem_rdata_o,

  input  logic                   mem_stall_i
);

  import memcopy_pkg::*;

  logic   start;
  logic   done;
  addr_t  ptr_read;
  addr_t  ptr_write;
  count_t count;

  logic   mem_req;
  logic   mem_we;
  addr_t  mem_addr;
  data_t  mem_wdata;
  logic   mem_gnt;
  logic   mem_rvalid;
  data_t  mem_rdata;

  memcopy_regs i_memcopy_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ready_o (reg_ready_o),
    .reg_error_o (reg_error_o),
    .start_o     (start),
    .ptr_read_o  (ptr_read),
    .ptr_write_o (ptr_write),
    .count_o     (count),
    .done_i      (done)
  );

  memcopy_engine i_memcopy_engine (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .ptr_read_i   (ptr_read),
    .ptr_write_i  (ptr_write),
    .count_i      (count),
    .done_o       (done),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_gnt_i    (mem_gnt),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata)
  );

  memcopy_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) i_memcopy_sram (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_req_i    (mem_req),
    .mem_we_i     (mem_we),
    .mem_addr_i   (mem_addr),
    .mem_wdata_i  (mem_wdata),
    .mem_gnt_o    (mem_gnt),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata),
    .mem_stall_i  (mem_stall_i),
    .host_req_i   (host_mem_req_i),
    .host_we_i    (host_mem_we_i),
    .host_addr_i  (host_mem_addr_i),
    .host_wdata_i (host_mem_wdata_i),
    .host_rdata_o (host_mem_rdata_o)
  );

endmodule
